// File: source/melody_pkg.sv
`default_nettype none

package melody_pkg;

	typedef logic [6:0] note_t;
	typedef logic [13:0] freq_t;
	typedef logic [18:0] half_acc_t;
	typedef logic [3:0] step_t;
	typedef logic [7:0] dur_t;

	localparam note_t NOTE_REST = 7'd0;

	// Note numbers count semitones upward from C1 = 1
	localparam note_t C4 = 7'd37;
	localparam note_t Db4 = 7'd38;
	localparam note_t D4 = 7'd39;
	localparam note_t Eb4 = 7'd40;
	localparam note_t E4 = 7'd41;
	localparam note_t F4 = 7'd42;
	localparam note_t Gb4 = 7'd43;
	localparam note_t G4 = 7'd44;
	localparam note_t Ab4 = 7'd45;
	localparam note_t A4 = 7'd46;
	localparam note_t Bb4 = 7'd47;
	localparam note_t B4 = 7'd48;
	localparam note_t C5 = 7'd49;
	localparam note_t Db5 = 7'd50;
	localparam note_t D5 = 7'd51;
	localparam note_t Eb5 = 7'd52;
	localparam note_t E5 = 7'd53;
	localparam note_t F5 = 7'd54;
	localparam note_t Gb5 = 7'd55;
	localparam note_t G5 = 7'd56;
	localparam note_t Ab5 = 7'd57;
	localparam note_t A5 = 7'd58;
	localparam note_t Bb5 = 7'd59;
	localparam note_t B5 = 7'd60;

	localparam int SCORE_LEN = 16;

	// Every note is followed by a rest of the same length
	localparam note_t SCORE_NOTE [SCORE_LEN] = '{
		D4, NOTE_REST,
		D5, NOTE_REST,
		A4, NOTE_REST,
		G4, NOTE_REST,
		F4, NOTE_REST,
		D4, NOTE_REST,
		F4, NOTE_REST,
		G4, NOTE_REST
	};

	// Lengths in time-base steps
	localparam dur_t SCORE_DUR [SCORE_LEN] = '{
		8'd62, 8'd62,
		8'd125, 8'd125,
		8'd187, 8'd187,
		8'd125, 8'd125,
		8'd125, 8'd125,
		8'd62, 8'd62,
		8'd62, 8'd62,
		8'd62, 8'd62
	};

	// Accumulator threshold for one half period of the buzzer wave
	localparam half_acc_t HALF_PERIOD_LIMIT = 19'd500000;

endpackage

`default_nettype wire

// File: source/tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
	parameter int SYS_FREQ_MHZ = 125,
	parameter int TIME_BASE_US = 1000
) (
	input wire clk,
	input wire reset_p,
	input wire base_en,
	output logic usec_tick,
	output logic base_tick
);

	localparam int USEC_W = (SYS_FREQ_MHZ > 1) ? $clog2(SYS_FREQ_MHZ) : 1;
	localparam int BASE_W = (TIME_BASE_US > 1) ? $clog2(TIME_BASE_US) : 1;

	logic [USEC_W-1:0] usec_cnt;
	logic [BASE_W-1:0] base_cnt;
	logic base_last;

	// Free-running microsecond divider
	always_ff @(posedge clk or posedge reset_p) begin
		if (reset_p) begin
			usec_cnt <= '0;
			usec_tick <= 1'b0;
		end else if (usec_cnt == USEC_W'(SYS_FREQ_MHZ - 1)) begin
			usec_cnt <= '0;
			usec_tick <= 1'b1;
		end else begin
			usec_cnt <= usec_cnt + 1'b1;
			usec_tick <= 1'b0;
		end
	end

	assign base_last = (base_cnt == BASE_W'(TIME_BASE_US - 1));

	// Time base restarts from zero whenever playback starts
	always_ff @(posedge clk or posedge reset_p) begin
		if (reset_p) begin
			base_cnt <= '0;
		end else if (!base_en) begin
			base_cnt <= '0;
		end else if (usec_tick) begin
			base_cnt <= base_last ? '0 : base_cnt + 1'b1;
		end
	end

	assign base_tick = usec_tick & base_en & base_last;

endmodule

`default_nettype wire

// File: source/switch_edge.sv
`timescale 1ns/1ps
`default_nettype none

module switch_edge (
	input wire clk,
	input wire reset_p,
	input wire play_switch,
	output logic switch_rise,
	output logic switch_fall
);

	logic [1:0] sync;
	logic sync_d;

	// Two-flop synchronizer plus one delayed copy for edge detection
	always_ff @(posedge clk or posedge reset_p) begin
		if (reset_p) begin
			sync <= 2'b00;
			sync_d <= 1'b0;
		end else begin
			sync <= {sync[0], play_switch};
			sync_d <= sync[1];
		end
	end

	assign switch_rise = sync[1] & ~sync_d;
	assign switch_fall = ~sync[1] & sync_d;

endmodule

`default_nettype wire

// File: source/melody_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module melody_sequencer (
	input wire clk,
	input wire reset_p,
	input wire switch_rise,
	input wire switch_fall,
	input wire base_tick,
	output melody_pkg::note_t note,
	output logic playing,
	output logic stop,
	output logic base_en
);

	import melody_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_PLAY
	} seq_state_t;

	seq_state_t state;
	step_t step;
	step_t next_step;
	dur_t elapsed;
	logic step_end;
	logic last_step;

	assign next_step = step + 1'b1;
	assign last_step = (step == step_t'(SCORE_LEN - 1));

	// Step is over on the base tick that reaches its duration
	assign step_end = (dur_t'(elapsed + 1'b1) == SCORE_DUR[step]);

	always_ff @(posedge clk or posedge reset_p) begin
		if (reset_p) begin
			state <= ST_IDLE;
			step <= '0;
			elapsed <= '0;
			note <= NOTE_REST;
		end else if (switch_rise) begin
			// Restart always begins at the first step
			state <= ST_PLAY;
			step <= '0;
			elapsed <= '0;
			note <= SCORE_NOTE[0];
		end else if (switch_fall) begin
			state <= ST_IDLE;
			step <= '0;
			elapsed <= '0;
			note <= NOTE_REST;
		end else if (state == ST_PLAY && base_tick) begin
			if (step_end) begin
				elapsed <= '0;
				if (last_step) begin
					state <= ST_IDLE;
					step <= '0;
					note <= NOTE_REST;
				end else begin
					step <= next_step;
					note <= SCORE_NOTE[next_step];
				end
			end else begin
				elapsed <= elapsed + 1'b1;
			end
		end
	end

	assign playing = (state == ST_PLAY);
	assign stop = (state == ST_IDLE);

	// Time base only runs during playback
	assign base_en = playing;

endmodule

`default_nettype wire

// File: source/tone_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tone_gen (
	input wire clk,
	input wire reset_p,
	input melody_pkg::note_t note,
	input wire stop,
	input wire usec_tick,
	output logic buz_clk
);

	import melody_pkg::*;

	freq_t freq;
	half_acc_t half_acc;

	// Note number to frequency in Hz, equal temperament from C1
	always_ff @(posedge clk or posedge reset_p) begin
		if (reset_p) begin
			freq <= 14'd1;
		end else begin
			case (note)
				7'd1: freq <= 14'd33;
				7'd2: freq <= 14'd35;
				7'd3: freq <= 14'd37;
				7'd4: freq <= 14'd39;
				7'd5: freq <= 14'd41;
				7'd6: freq <= 14'd44;
				7'd7: freq <= 14'd46;
				7'd8: freq <= 14'd49;
				7'd9: freq <= 14'd52;
				7'd10: freq <= 14'd55;
				7'd11: freq <= 14'd58;
				7'd12: freq <= 14'd62;
				7'd13: freq <= 14'd65;
				7'd14: freq <= 14'd69;
				7'd15: freq <= 14'd73;
				7'd16: freq <= 14'd78;
				7'd17: freq <= 14'd82;
				7'd18: freq <= 14'd87;
				7'd19: freq <= 14'd92;
				7'd20: freq <= 14'd98;
				7'd21: freq <= 14'd104;
				7'd22: freq <= 14'd110;
				7'd23: freq <= 14'd117;
				7'd24: freq <= 14'd123;
				7'd25: freq <= 14'd131;
				7'd26: freq <= 14'd139;
				7'd27: freq <= 14'd147;
				7'd28: freq <= 14'd156;
				7'd29: freq <= 14'd165;
				7'd30: freq <= 14'd175;
				7'd31: freq <= 14'd185;
				7'd32: freq <= 14'd196;
				7'd33: freq <= 14'd208;
				7'd34: freq <= 14'd220;
				7'd35: freq <= 14'd233;
				7'd36: freq <= 14'd247;
				7'd37: freq <= 14'd262;
				7'd38: freq <= 14'd277;
				7'd39: freq <= 14'd294;
				7'd40: freq <= 14'd311;
				7'd41: freq <= 14'd330;
				7'd42: freq <= 14'd349;
				7'd43: freq <= 14'd370;
				7'd44: freq <= 14'd392;
				7'd45: freq <= 14'd415;
				7'd46: freq <= 14'd440;
				7'd47: freq <= 14'd466;
				7'd48: freq <= 14'd494;
				7'd49: freq <= 14'd523;
				7'd50: freq <= 14'd554;
				7'd51: freq <= 14'd587;
				7'd52: freq <= 14'd622;
				7'd53: freq <= 14'd659;
				7'd54: freq <= 14'd698;
				7'd55: freq <= 14'd740;
				7'd56: freq <= 14'd784;
				7'd57: freq <= 14'd831;
				7'd58: freq <= 14'd880;
				7'd59: freq <= 14'd932;
				7'd60: freq <= 14'd988;
				7'd61: freq <= 14'd1047;
				7'd62: freq <= 14'd1109;
				7'd63: freq <= 14'd1175;
				7'd64: freq <= 14'd1245;
				7'd65: freq <= 14'd1319;
				7'd66: freq <= 14'd1397;
				7'd67: freq <= 14'd1480;
				7'd68: freq <= 14'd1568;
				7'd69: freq <= 14'd1661;
				7'd70: freq <= 14'd1760;
				7'd71: freq <= 14'd1865;
				7'd72: freq <= 14'd1976;
				7'd73: freq <= 14'd2093;
				7'd74: freq <= 14'd2217;
				7'd75: freq <= 14'd2349;
				7'd76: freq <= 14'd2489;
				7'd77: freq <= 14'd2637;
				7'd78: freq <= 14'd2794;
				7'd79: freq <= 14'd2960;
				7'd80: freq <= 14'd3136;
				7'd81: freq <= 14'd3322;
				7'd82: freq <= 14'd3520;
				7'd83: freq <= 14'd3729;
				7'd84: freq <= 14'd3951;
				7'd85: freq <= 14'd4186;
				7'd86: freq <= 14'd4435;
				7'd87: freq <= 14'd4699;
				7'd88: freq <= 14'd4978;
				7'd89: freq <= 14'd5274;
				7'd90: freq <= 14'd5588;
				7'd91: freq <= 14'd5920;
				7'd92: freq <= 14'd6272;
				7'd93: freq <= 14'd6645;
				7'd94: freq <= 14'd7040;
				7'd95: freq <= 14'd7459;
				7'd96: freq <= 14'd7902;
				7'd97: freq <= 14'd8372;
				7'd98: freq <= 14'd8870;
				7'd99: freq <= 14'd9397;
				7'd100: freq <= 14'd9956;
				7'd101: freq <= 14'd10548;
				7'd102: freq <= 14'd11175;
				7'd103: freq <= 14'd11840;
				7'd104: freq <= 14'd12544;
				7'd105: freq <= 14'd13290;
				7'd106: freq <= 14'd14080;
				7'd107: freq <= 14'd14917;
				7'd108: freq <= 14'd15804;
				// Rest and out-of-range numbers sit at 1 Hz
				default: freq <= 14'd1;
			endcase
		end
	end

	// Adds f every microsecond, so the limit is crossed twice per period
	always_ff @(posedge clk or posedge reset_p) begin
		if (reset_p) begin
			half_acc <= '0;
			buz_clk <= 1'b0;
		end else if (!stop && usec_tick) begin
			if (half_acc > HALF_PERIOD_LIMIT) begin
				half_acc <= '0;
				buz_clk <= ~buz_clk;
			end else begin
				half_acc <= half_acc + half_acc_t'(freq);
			end
		end
	end

endmodule

`default_nettype wire

// File: source/melody_player.sv
`timescale 1ns/1ps
`default_nettype none

module melody_player #(
	parameter int SYS_FREQ_MHZ = 125,
	parameter int TIME_BASE_US = 1000
) (
	input wire clk,
	input wire reset_p,
	input wire play_switch,
	output logic buz_clk,
	output melody_pkg::note_t note,
	output logic playing
);

	logic usec_tick;
	logic base_tick;
	logic base_en;
	logic switch_rise;
	logic switch_fall;
	logic stop;

	tick_gen #(
		.SYS_FREQ_MHZ(SYS_FREQ_MHZ),
		.TIME_BASE_US(TIME_BASE_US)
	) u_tick_gen (
		.clk(clk),
		.reset_p(reset_p),
		.base_en(base_en),
		.usec_tick(usec_tick),
		.base_tick(base_tick)
	);

	switch_edge u_switch_edge (
		.clk(clk),
		.reset_p(reset_p),
		.play_switch(play_switch),
		.switch_rise(switch_rise),
		.switch_fall(switch_fall)
	);

	melody_sequencer u_melody_sequencer (
		.clk(clk),
		.reset_p(reset_p),
		.switch_rise(switch_rise),
		.switch_fall(switch_fall),
		.base_tick(base_tick),
		.note(note),
		.playing(playing),
		.stop(stop),
		.base_en(base_en)
	);

	tone_gen u_tone_gen (
		.clk(clk),
		.reset_p(reset_p),
		.note(note),
		.stop(stop),
		.usec_tick(usec_tick),
		.buz_clk(buz_clk)
	);

endmodule

`default_nettype wire

// File: sim/melody_player_properties.sv
`timescale 1ns/1ps
`default_nettype none

module melody_player_properties (
	input wire clk,
	input wire reset_p,
	input wire playing,
	input wire buz_clk,
	input melody_pkg::note_t note,
	input wire base_tick,
	input wire switch_rise,
	input wire switch_fall
);

	int fail_count = 0;

	// Tone generator is frozen while idle
	property quiet_when_idle;
		@(posedge clk) disable iff (reset_p)
		!playing |=> $stable(buz_clk);
	endproperty

	property note_moves_on_events;
		@(posedge clk) disable iff (reset_p)
		(note != $past(note)) |-> $past(base_tick || switch_rise || switch_fall);
	endproperty

	// End of score always coincides with a base tick
	property stop_on_fall_or_end;
		@(posedge clk) disable iff (reset_p)
		$fell(playing) |-> $past(switch_fall || base_tick);
	endproperty

	assert property (quiet_when_idle)
	else begin
		fail_count++;
		$error("ERR buz_clk=%h changed while idle", $sampled(buz_clk));
	end

	assert property (note_moves_on_events)
	else begin
		fail_count++;
		$error("ERR note=%h changed without a tick or switch edge", $sampled(note));
	end

	assert property (stop_on_fall_or_end)
	else begin
		fail_count++;
		$error("playing fell without a switch fall or the end of the score");
	end

endmodule

bind melody_player melody_player_properties u_melody_player_properties (
	.clk(clk),
	.reset_p(reset_p),
	.playing(playing),
	.buz_clk(buz_clk),
	.note(note),
	.base_tick(base_tick),
	.switch_rise(switch_rise),
	.switch_fall(switch_fall)
);

`default_nettype wire

// File: sim/melody_player_tb.sv
`timescale 1ns/1ps
`default_nettype none

module melody_player_tb;

	import melody_pkg::*;

	localparam int SYS_FREQ_MHZ = 25;
	localparam int TIME_BASE_US = 10;
	localparam int USEC_CYC = SYS_FREQ_MHZ;
	localparam int BASE_CYC = SYS_FREQ_MHZ * TIME_BASE_US;
	localparam int SCORE_CYC_MAX = 420000;

	logic clk;
	logic reset_p;
	logic play_switch;
	logic buz_clk;
	note_t note;
	logic playing;

	int errors;
	int timeouts;
	int total;
	logic started;
	logic [31:0] seed;
	int abort_step;

	// Score position as seen from the outputs
	note_t note_d;
	logic playing_d;
	logic buz_d;
	int step_idx;
	int step_cycles;
	int hp_cycles;
	logic hp_valid;

	melody_player #(
		.SYS_FREQ_MHZ(SYS_FREQ_MHZ),
		.TIME_BASE_US(TIME_BASE_US)
	) u_melody_player (
		.clk(clk),
		.reset_p(reset_p),
		.play_switch(play_switch),
		.buz_clk(buz_clk),
		.note(note),
		.playing(playing)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Reference pitches of the notes in the score
	function automatic int ref_freq(input note_t n);
		case (n)
			D4: return 294;
			F4: return 349;
			G4: return 392;
			A4: return 440;
			D5: return 587;
			default: return 0;
		endcase
	endfunction

	function automatic note_t score_note(input int idx);
		if (idx < 0 || idx >= SCORE_LEN)
			return 7'h7f;
		return SCORE_NOTE[idx];
	endfunction

	function automatic bit step_len_ok(input int idx, input int cycles);
		int dur;
		if (idx < 0 || idx >= SCORE_LEN)
			return 1'b0;
		dur = int'(SCORE_DUR[idx]);
		// First base tick of a run can land up to one microsecond early
		return (cycles >= dur * BASE_CYC - USEC_CYC) &&
			(cycles <= (dur + 1) * BASE_CYC + 4);
	endfunction

	function automatic bit half_period_ok(input note_t n, input int cycles);
		int f;
		int nominal;
		f = ref_freq(n);
		if (f == 0)
			return 1'b0;
		nominal = (int'(HALF_PERIOD_LIMIT) / f + 2) * USEC_CYC;
		return (cycles >= nominal - USEC_CYC) && (cycles <= nominal + USEC_CYC);
	endfunction

	always @(posedge clk or posedge reset_p) begin
		if (reset_p) begin
			note_d <= NOTE_REST;
			playing_d <= 1'b0;
			buz_d <= 1'b0;
			step_idx <= 0;
			step_cycles <= 0;
			hp_cycles <= 0;
			hp_valid <= 1'b0;
		end else begin
			note_d <= note;
			playing_d <= playing;
			buz_d <= buz_clk;
			if (playing && !playing_d) begin
				step_idx <= 0;
				step_cycles <= 1;
			end else if (playing && note != note_d) begin
				step_idx <= step_idx + 1;
				step_cycles <= 1;
			end else begin
				step_cycles <= step_cycles + 1;
			end
			// A half period counts only if one pitched note covers all of it
			if (buz_clk != buz_d) begin
				hp_cycles <= 1;
				hp_valid <= playing && note != NOTE_REST && note == note_d;
			end else begin
				hp_cycles <= hp_cycles + 1;
				if (!playing || note != note_d)
					hp_valid <= 1'b0;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset_p)
		!started |-> (buz_clk == 1'b0 && note == NOTE_REST && !playing))
	else begin
		errors++;
		$display("ERR before start buz_clk=%h note=%h playing=%h",
			$sampled(buz_clk), $sampled(note), $sampled(playing));
	end

	assert property (@(posedge clk) disable iff (reset_p)
		$rose(play_switch) |-> ##[1:4] (playing && note == SCORE_NOTE[0]))
	else begin
		errors++;
		$display("ERR after rise playing=%h note=%h expected note %h",
			$sampled(playing), $sampled(note), SCORE_NOTE[0]);
	end

	assert property (@(posedge clk) disable iff (reset_p)
		$fell(play_switch) |-> ##[1:4] (!playing && note == NOTE_REST))
	else begin
		errors++;
		$display("ERR after fall playing=%h note=%h",
			$sampled(playing), $sampled(note));
	end

	assert property (@(posedge clk) disable iff (reset_p)
		(playing && playing_d && note != note_d) |-> (note == score_note(step_idx + 1)))
	else begin
		errors++;
		$display("ERR note=%h expected %h", $sampled(note), score_note($sampled(step_idx) + 1));
	end

	assert property (@(posedge clk) disable iff (reset_p)
		(playing && playing_d && note != note_d) || (!playing && playing_d && play_switch)
		|-> step_len_ok(step_idx, step_cycles))
	else begin
		errors++;
		$display("ERR step_cycles=%h out of range for step %h",
			$sampled(step_cycles), $sampled(step_idx));
	end

	// Natural end only after the last step
	assert property (@(posedge clk) disable iff (reset_p)
		(!playing && playing_d && play_switch) |-> (step_idx == SCORE_LEN - 1))
	else begin
		errors++;
		$display("ERR step_idx=%h at end of score, expected %h",
			$sampled(step_idx), SCORE_LEN - 1);
	end

	assert property (@(posedge clk) disable iff (reset_p)
		!playing |-> (note == NOTE_REST))
	else begin
		errors++;
		$display("ERR note=%h while idle, expected %h", $sampled(note), NOTE_REST);
	end

	assert property (@(posedge clk) disable iff (reset_p)
		(buz_clk != buz_d && hp_valid && note == note_d) |-> half_period_ok(note, hp_cycles))
	else begin
		errors++;
		$display("ERR half period hp_cycles=%h for note=%h",
			$sampled(hp_cycles), $sampled(note));
	end

	task automatic wait_playing(input logic level, input int limit);
		int count;
		count = 0;
		while (playing !== level && count < limit) begin
			@(negedge clk);
			count++;
		end
		if (playing !== level) begin
			timeouts++;
			$display("Timed out after %0d cycles waiting for playing to become %0d",
				limit, level);
		end
	endtask

	task automatic wait_step(input int idx, input int limit);
		int count;
		count = 0;
		while (!(playing && step_idx == idx) && count < limit) begin
			@(negedge clk);
			count++;
		end
		if (!(playing && step_idx == idx)) begin
			timeouts++;
			$display("Timed out after %0d cycles waiting for step %0d", limit, idx);
		end
	endtask

	initial begin
		reset_p = 1'b1;
		play_switch = 1'b0;
		started = 1'b0;
		errors = 0;
		timeouts = 0;
		seed = 32'h666;
		repeat (8) @(posedge clk);
		reset_p <= 1'b0;
		repeat (200) @(posedge clk);

		// Full pass through the score
		play_switch <= 1'b1;
		started <= 1'b1;
		wait_playing(1'b1, 10);
		wait_playing(1'b0, SCORE_CYC_MAX);
		repeat (2000) @(posedge clk);
		play_switch <= 1'b0;
		repeat (20) @(posedge clk);

		// Abort somewhere inside the score
		seed = lcg_next(seed);
		abort_step = 1 + int'(seed[23:16]) % (SCORE_LEN - 2);
		play_switch <= 1'b1;
		wait_playing(1'b1, 10);
		wait_step(abort_step, SCORE_CYC_MAX);
		repeat (100) @(posedge clk);
		play_switch <= 1'b0;
		wait_playing(1'b0, 10);
		repeat (50) @(posedge clk);

		// Restart plays from the top again
		play_switch <= 1'b1;
		wait_playing(1'b1, 10);
		wait_playing(1'b0, SCORE_CYC_MAX);
		repeat (2000) @(posedge clk);

		total = errors + timeouts + u_melody_player.u_melody_player_properties.fail_count;
		$display("Checks done: %0d assertion errors, %0d property errors, %0d timeouts",
			errors, u_melody_player.u_melody_player_properties.fail_count, timeouts);
		if (total == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
source/melody_pkg.sv
source/tick_gen.sv
source/switch_edge.sv
source/melody_sequencer.sv
source/tone_gen.sv
source/melody_player.sv
sim/melody_player_properties.sv
sim/melody_player_tb.sv
